// ==== copper_cfg.svh ====
`ifndef COPPER_CFG_SVH
`define COPPER_CFG_SVH

// Datapath widths
`define COPP_PC_W           11
`define COPP_WORD_W         16
`define COPP_POS_W          11

// Video timing totals, in pixels and lines
`define COPP_H_TOTAL        800
`define COPP_V_TOTAL        525

// Restart fires this many pixels before the end of the last line
`define COPP_RESTART_H_LEAD 5

// Bus address bases for palette and copper memory targets
`define COPP_COLOR_BASE     16'h8000
`define COPP_MEM_BASE       16'hC000

// Opcodes, top nibble of the first word
`define COPP_OP_WAIT        4'd0
`define COPP_OP_SKIP        4'd2
`define COPP_OP_JMP         4'd4
`define COPP_OP_MOVER       4'd9
`define COPP_OP_MOVEP       4'd11
`define COPP_OP_MOVEC       4'd12

// Host interface
`define COPP_APB_AW         13

`endif

// ==== copper_pkg.sv ====
`include "copper_cfg.svh"

package copper_pkg;

    // Instruction word, first word in the upper half
    // Position form is used by WAIT, SKIP and JMP
    // Move form is used by all MOVEx variants
    typedef union packed {
        struct packed {
            logic [3:0]             opcode;
            logic                   rsvd_y;
            logic [`COPP_POS_W-1:0] y;
            logic                   rsvd_x;
            logic [`COPP_POS_W-1:0] x;
            // Bit 0 ignores vertical, bit 1 ignores horizontal
            logic [3:0]             flags;
        } pos_view;
        struct packed {
            logic [3:0]              opcode;
            logic [11:0]             target;
            logic [`COPP_WORD_W-1:0] data;
        } move_view;
    } copp_insn_u;

    // Fetch stage offer to execute
    typedef struct packed {
        logic                  valid;
        logic                  flush;
        copp_insn_u            insn;
        // Address of the first instruction word
        logic [`COPP_PC_W-1:0] pc;
    } copp_fetch_t;

    // Execute stage reply to fetch
    typedef struct packed {
        logic                  accept;
        logic                  taken;
        logic [`COPP_PC_W-1:0] target;
    } copp_redirect_t;

    // Single write, used on the video bus and for copper memory
    typedef struct packed {
        logic [`COPP_WORD_W-1:0] addr;
        logic [`COPP_WORD_W-1:0] data;
    } copp_bus_wr_t;

endpackage

// ==== copper_apb_regs.sv ====
`timescale 1ns/1ns
`include "copper_cfg.svh"

module copper_apb_regs
    import copper_pkg::*;
(
    input  logic                    clk,
    input  logic                    copp_reset,
    input  logic                    psel_i,
    input  logic                    penable_i,
    input  logic                    pwrite_i,
    input  logic [`COPP_APB_AW-1:0] paddr_i,
    input  logic [`COPP_WORD_W-1:0] pwdata_i,
    output logic [`COPP_WORD_W-1:0] prdata_o,
    output logic                    pready_o,
    output logic                    pslverr_o,
    output logic                    enable_o,
    output logic [`COPP_PC_W-1:0]   init_pc_o,
    output logic                    host_wr_valid_o,
    output copp_bus_wr_t            host_wr_o
);

    logic                  acc_wr;
    logic                  ctrl_sel;
    logic                  win_sel;
    logic                  enable_q;
    logic [`COPP_PC_W-1:0] init_pc_q;

    // Zero wait states, never an error
    assign pready_o  = 1'b1;
    assign pslverr_o = 1'b0;

    assign enable_o  = enable_q;
    assign init_pc_o = init_pc_q;

    always_comb begin
        // Writes take effect in the access phase
        acc_wr   = psel_i && penable_i && pwrite_i;
        ctrl_sel = paddr_i == '0;
        // Window 0x800..0xFFF, word index in the low bits
        win_sel  = paddr_i[`COPP_APB_AW-1:`COPP_PC_W] == 2'b01;

        // Only the control register reads back
        if (ctrl_sel) begin
            prdata_o = {enable_q, {(`COPP_WORD_W-`COPP_PC_W-1){1'b0}}, init_pc_q};
        end else begin
            prdata_o = '0;
        end

        // One-cycle program memory write, wins over MOVEC in the RAM
        host_wr_valid_o = acc_wr && win_sel;
        host_wr_o.addr  = `COPP_MEM_BASE |
                          {{(`COPP_WORD_W-`COPP_PC_W){1'b0}}, paddr_i[`COPP_PC_W-1:0]};
        host_wr_o.data  = pwdata_i;
    end

    // Control register, enable in bit 15 and initial PC in the low bits
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            enable_q  <= 1'b0;
            init_pc_q <= '0;
        end else if (acc_wr && ctrl_sel) begin
            enable_q  <= pwdata_i[`COPP_WORD_W-1];
            init_pc_q <= pwdata_i[`COPP_PC_W-1:0];
        end
    end

    // Host must open every transfer with a setup phase
    a_penable_needs_psel: assert property (
        @(posedge clk) disable iff (copp_reset)
        penable_i |-> psel_i
    );

endmodule

// ==== copper_prog_ram.sv ====
`timescale 1ns/1ns
`include "copper_cfg.svh"

module copper_prog_ram
    import copper_pkg::*;
(
    input  logic                    clk,
    input  logic [`COPP_PC_W-1:0]   rd_addr_i,
    output logic [`COPP_WORD_W-1:0] rd_data_o,
    input  logic                    host_wr_valid_i,
    input  copp_bus_wr_t            host_wr_i,
    input  logic                    copp_wr_valid_i,
    input  copp_bus_wr_t            copp_wr_i,
    output logic                    copp_wr_grant_o
);

    logic [`COPP_WORD_W-1:0] mem [0:(1<<`COPP_PC_W)-1];

    logic                    wr_en;
    logic [`COPP_PC_W-1:0]   wr_addr;
    logic [`COPP_WORD_W-1:0] wr_data;

    always_comb begin
        // Host write always wins, MOVEC retries next cycle
        copp_wr_grant_o = copp_wr_valid_i && !host_wr_valid_i;
        wr_en           = host_wr_valid_i || copp_wr_valid_i;
        // Upper address bits carry the memory base only
        if (host_wr_valid_i) begin
            wr_addr = host_wr_i.addr[`COPP_PC_W-1:0];
            wr_data = host_wr_i.data;
        end else begin
            wr_addr = copp_wr_i.addr[`COPP_PC_W-1:0];
            wr_data = copp_wr_i.data;
        end
    end

    // Single write port, registered read returns old data on collision
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

// ==== copper_fetch.sv ====
`timescale 1ns/1ns
`include "copper_cfg.svh"

module copper_fetch
    import copper_pkg::*;
(
    input  logic                    clk,
    input  logic                    copp_reset,
    input  logic                    enable_i,
    input  logic [`COPP_PC_W-1:0]   init_pc_i,
    input  logic [`COPP_POS_W-1:0]  h_count_i,
    input  logic [`COPP_POS_W-1:0]  v_count_i,
    output logic [`COPP_PC_W-1:0]   rd_addr_o,
    input  logic [`COPP_WORD_W-1:0] rd_data_i,
    output copp_fetch_t             fetch_o,
    input  copp_redirect_t          redirect_i
);

    localparam logic [`COPP_POS_W-1:0] RESTART_H =
        (`COPP_POS_W)'(`COPP_H_TOTAL - `COPP_RESTART_H_LEAD);
    localparam logic [`COPP_POS_W-1:0] RESTART_V = (`COPP_POS_W)'(`COPP_V_TOTAL - 1);

    logic                    at_restart;
    logic                    at_restart_q;
    logic                    restart;
    logic                    pop;
    logic                    push;
    logic                    kill;
    logic                    wr_idx;
    logic                    flush_q;
    // 0 issue first word, 1 issue second word, 2 capture second word
    logic [1:0]              phase_q;
    logic [1:0]              count_q;
    logic [`COPP_PC_W-1:0]   pc_q;
    logic [`COPP_WORD_W-1:0] hi_q;
    // Entry 0 is offered to execute, entry 1 is the prefetch
    copp_insn_u              buf_insn_q [2];
    logic [`COPP_PC_W-1:0]   buf_pc_q [2];

    always_comb begin
        fetch_o.valid = count_q != 2'd0;
        fetch_o.flush = flush_q;
        fetch_o.insn  = buf_insn_q[0];
        fetch_o.pc    = buf_pc_q[0];

        // Restart on arrival at the position, not while parked there
        at_restart = (h_count_i == RESTART_H) && (v_count_i == RESTART_V);
        restart    = at_restart && !at_restart_q;
        pop        = fetch_o.valid && redirect_i.accept;
        push       = phase_q == 2'd2;
        kill       = restart || !enable_i || (pop && redirect_i.taken);
        // Free slot index after this cycle's pop
        wr_idx     = count_q[0] ^ pop;
        rd_addr_o  = (phase_q == 2'd1) ? pc_q + 1'b1 : pc_q;
    end

    always_ff @(posedge clk) begin
        if (copp_reset) begin
            at_restart_q <= 1'b0;
            flush_q      <= 1'b0;
            phase_q      <= 2'd0;
            count_q      <= 2'd0;
            pc_q         <= '0;
        end else begin
            at_restart_q <= at_restart;
            flush_q      <= restart || !enable_i;
            if (kill) begin
                // Drop buffer and any fetch in flight
                phase_q <= 2'd0;
                count_q <= 2'd0;
                pc_q    <= (restart || !enable_i) ? init_pc_i : redirect_i.target;
            end else begin
                case (phase_q)
                    // Start only with a slot free at push time
                    2'd0: if (count_q != 2'd2) phase_q <= 2'd1;
                    2'd1: phase_q <= 2'd2;
                    default: begin
                        phase_q <= 2'd0;
                        pc_q    <= pc_q + 2'd2;
                    end
                endcase
                count_q <= count_q + {1'b0, push} - {1'b0, pop};
            end
        end
    end

    // Instruction words and buffer contents
    always_ff @(posedge clk) begin
        if (phase_q == 2'd1) begin
            hi_q <= rd_data_i;
        end
        if (pop) begin
            buf_insn_q[0] <= buf_insn_q[1];
            buf_pc_q[0]   <= buf_pc_q[1];
        end
        if (push) begin
            buf_insn_q[wr_idx] <= {hi_q, rd_data_i};
            buf_pc_q[wr_idx]   <= pc_q;
        end
    end

    // Offer holds until execute takes it
    a_offer_stable: assert property (
        @(posedge clk) disable iff (copp_reset)
        fetch_o.valid && !redirect_i.accept && !kill |=> $stable(fetch_o)
    );

endmodule

// ==== copper_exec.sv ====
`timescale 1ns/1ns
`include "copper_cfg.svh"

module copper_exec
    import copper_pkg::*;
(
    input  logic                   clk,
    input  logic                   copp_reset,
    input  copp_fetch_t            fetch_i,
    output copp_redirect_t         redirect_o,
    input  logic [`COPP_POS_W-1:0] h_count_i,
    input  logic [`COPP_POS_W-1:0] v_count_i,
    output logic                   bus_wr_valid_o,
    output copp_bus_wr_t           bus_wr_o,
    input  logic                   bus_wr_ready_i,
    output logic                   mem_wr_valid_o,
    output copp_bus_wr_t           mem_wr_o,
    input  logic                   mem_wr_grant_i
);

    copp_insn_u            insn;
    logic                  ign_v;
    logic                  ign_h;
    logic                  pos_hit;
    logic                  bus_done;
    logic                  mem_done;
    logic                  busy;
    logic                  start;
    logic                  accept_q;
    logic                  taken_q;
    logic [`COPP_PC_W-1:0] target_q;

    always_comb begin
        insn    = fetch_i.insn;
        ign_v   = insn.pos_view.flags[0];
        ign_h   = insn.pos_view.flags[1];
        // Reached means at or past every position that is checked
        pos_hit = (ign_v || v_count_i >= insn.pos_view.y) &&
                  (ign_h || h_count_i >= insn.pos_view.x);

        bus_done = bus_wr_valid_o && bus_wr_ready_i;
        mem_done = mem_wr_valid_o && mem_wr_grant_i;
        busy     = accept_q || bus_wr_valid_o || mem_wr_valid_o;
        // WAIT re-evaluates here every cycle until released
        start    = fetch_i.valid && !busy;

        // Moves complete in the cycle their write is taken
        redirect_o.accept = accept_q || bus_done || mem_done;
        redirect_o.taken  = taken_q;
        redirect_o.target = target_q;
    end

    always_ff @(posedge clk) begin
        if (copp_reset || fetch_i.flush) begin
            accept_q       <= 1'b0;
            taken_q        <= 1'b0;
            bus_wr_valid_o <= 1'b0;
            mem_wr_valid_o <= 1'b0;
        end else begin
            accept_q <= 1'b0;
            if (bus_done) bus_wr_valid_o <= 1'b0;
            if (mem_done) mem_wr_valid_o <= 1'b0;
            if (start) begin
                taken_q <= 1'b0;
                case (insn.pos_view.opcode)
                    // Both positions ignored waits for the next restart
                    `COPP_OP_WAIT: accept_q <= pos_hit && !(ign_v && ign_h);
                    `COPP_OP_SKIP: begin
                        accept_q <= 1'b1;
                        taken_q  <= pos_hit;
                    end
                    `COPP_OP_JMP: begin
                        accept_q <= 1'b1;
                        taken_q  <= 1'b1;
                    end
                    `COPP_OP_MOVER, `COPP_OP_MOVEP: bus_wr_valid_o <= 1'b1;
                    `COPP_OP_MOVEC: begin
                        // Refetch after the write so patched code is seen
                        mem_wr_valid_o <= 1'b1;
                        taken_q        <= 1'b1;
                    end
                    // Illegal opcode acts as a NOP
                    default: accept_q <= 1'b1;
                endcase
            end
        end
    end

    // Payload only moves while idle, so held writes stay stable
    always_ff @(posedge clk) begin
        if (start) begin
            case (insn.pos_view.opcode)
                `COPP_OP_SKIP: target_q <= fetch_i.pc + (`COPP_PC_W)'(4);
                `COPP_OP_JMP:  target_q <= insn.pos_view.y;
                default:       target_q <= fetch_i.pc + (`COPP_PC_W)'(2);
            endcase
            // Register number or palette index in the low byte
            if (insn.move_view.opcode == `COPP_OP_MOVEP) begin
                bus_wr_o.addr <= `COPP_COLOR_BASE | {8'h00, insn.move_view.target[7:0]};
            end else begin
                bus_wr_o.addr <= {8'h00, insn.move_view.target[7:0]};
            end
            bus_wr_o.data <= insn.move_view.data;
            mem_wr_o.addr <= `COPP_MEM_BASE |
                {{(`COPP_WORD_W-`COPP_PC_W){1'b0}}, insn.move_view.target[`COPP_PC_W-1:0]};
            mem_wr_o.data <= insn.move_view.data;
        end
    end

    // A stalled write holds until the bus takes it, unless flushed
    a_bus_hold: assert property (
        @(posedge clk) disable iff (copp_reset)
        bus_wr_valid_o && !bus_wr_ready_i && !fetch_i.flush
            |=> bus_wr_valid_o && $stable(bus_wr_o)
    );

endmodule

// ==== copper_top.sv ====
`timescale 1ns/1ns
`include "copper_cfg.svh"

module copper_top
    import copper_pkg::*;
(
    input  logic                    clk,
    input  logic                    copp_reset,
    input  logic                    psel_i,
    input  logic                    penable_i,
    input  logic                    pwrite_i,
    input  logic [`COPP_APB_AW-1:0] paddr_i,
    input  logic [`COPP_WORD_W-1:0] pwdata_i,
    output logic [`COPP_WORD_W-1:0] prdata_o,
    output logic                    pready_o,
    output logic                    pslverr_o,
    input  logic [`COPP_POS_W-1:0]  h_count_i,
    input  logic [`COPP_POS_W-1:0]  v_count_i,
    output logic                    bus_wr_valid_o,
    output copp_bus_wr_t            bus_wr_o,
    input  logic                    bus_wr_ready_i
);

    logic                    enable;
    logic [`COPP_PC_W-1:0]   init_pc;
    logic                    host_wr_valid;
    copp_bus_wr_t            host_wr;
    logic [`COPP_PC_W-1:0]   rd_addr;
    logic [`COPP_WORD_W-1:0] rd_data;
    copp_fetch_t             fetch;
    copp_redirect_t          redirect;
    logic                    mem_wr_valid;
    copp_bus_wr_t            mem_wr;
    logic                    mem_wr_grant;

    // Host side, control register and program load window
    copper_apb_regs u_regs (
        .clk, .copp_reset,
        .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
        .prdata_o, .pready_o, .pslverr_o,
        .enable_o(enable), .init_pc_o(init_pc),
        .host_wr_valid_o(host_wr_valid), .host_wr_o(host_wr)
    );

    // Program store, shared by host load and MOVEC
    copper_prog_ram u_ram (
        .clk,
        .rd_addr_i(rd_addr), .rd_data_o(rd_data),
        .host_wr_valid_i(host_wr_valid), .host_wr_i(host_wr),
        .copp_wr_valid_i(mem_wr_valid), .copp_wr_i(mem_wr),
        .copp_wr_grant_o(mem_wr_grant)
    );

    copper_fetch u_fetch (
        .clk, .copp_reset,
        .enable_i(enable), .init_pc_i(init_pc),
        .h_count_i, .v_count_i,
        .rd_addr_o(rd_addr), .rd_data_i(rd_data),
        .fetch_o(fetch), .redirect_i(redirect)
    );

    copper_exec u_exec (
        .clk, .copp_reset,
        .fetch_i(fetch), .redirect_o(redirect),
        .h_count_i, .v_count_i,
        .bus_wr_valid_o, .bus_wr_o, .bus_wr_ready_i,
        .mem_wr_valid_o(mem_wr_valid), .mem_wr_o(mem_wr), .mem_wr_grant_i(mem_wr_grant)
    );

endmodule

// ==== tb_copper.sv ====
`timescale 1ns/1ns
`include "copper_cfg.svh"

module tb_copper
    import copper_pkg::*;
();

    localparam int CLK_PERIOD    = 8;
    localparam int WRITE_TIMEOUT = 200;

    // Cycle budget of each test adds up to the watchdog limit
    localparam int RESET_CYCLES   = 10;
    localparam int REGS_CYCLES    = 150;
    localparam int MOVES_CYCLES   = 400;
    localparam int WAIT_CYCLES    = 500;
    localparam int SKIP_CYCLES    = 400;
    localparam int JUMP_CYCLES    = 500;
    localparam int RESTART_CYCLES = 600;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + REGS_CYCLES + MOVES_CYCLES +
                                     WAIT_CYCLES + SKIP_CYCLES + JUMP_CYCLES + RESTART_CYCLES;

    // Beam position that restarts the program
    localparam logic [10:0] RESTART_H = 11'(`COPP_H_TOTAL - `COPP_RESTART_H_LEAD);
    localparam logic [10:0] RESTART_V = 11'(`COPP_V_TOTAL - 1);

    logic         clk = 1'b0;
    logic         copp_reset;
    logic         psel;
    logic         penable;
    logic         pwrite;
    logic [12:0]  paddr;
    logic [15:0]  pwdata;
    logic [15:0]  prdata;
    logic         pready;
    logic         pslverr;
    logic [10:0]  h_count;
    logic [10:0]  v_count;
    logic         bus_wr_valid;
    copp_bus_wr_t bus_wr;
    logic         bus_wr_ready;
    logic [31:0]  lfsr;

    // Completed bus writes in arrival order
    copp_bus_wr_t seen_q[$];
    // Instructions waiting to be loaded
    logic [31:0]  prog_q[$];

    copper_top uut (
        .clk, .copp_reset,
        .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
        .paddr_i(paddr), .pwdata_i(pwdata),
        .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
        .h_count_i(h_count), .v_count_i(v_count),
        .bus_wr_valid_o(bus_wr_valid), .bus_wr_o(bus_wr), .bus_wr_ready_i(bus_wr_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // Position form with the first word in the upper half
    function automatic logic [31:0] enc_pos(input logic [3:0] op, input logic [10:0] y,
                                            input logic [10:0] x, input logic [3:0] flags);
        enc_pos = {op, 1'b0, y, 1'b0, x, flags};
    endfunction

    function automatic logic [31:0] enc_move(input logic [3:0] op, input logic [11:0] target,
                                             input logic [15:0] data);
        enc_move = {op, target, data};
    endfunction

    // WAIT with both positions ignored holds until the next restart
    function automatic logic [31:0] park_insn();
        park_insn = enc_pos(`COPP_OP_WAIT, 11'd0, 11'd0, 4'b0011);
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
        assert (act === exp) else begin
            abort_run($sformatf("mismatch at %0t ns: %s expected %h actual %h",
                                $time, name, exp, act));
        end
    endtask

    // The handshake completes at the rising edge
    always @(posedge clk) begin
        if (!copp_reset && bus_wr_valid && bus_wr_ready) begin
            seen_q.push_back(bus_wr);
        end
    end

    // Random back-pressure on the video bus
    initial begin
        lfsr         = 32'h1281_98c5;
        bus_wr_ready = 1'b0;
        forever begin
            @(negedge clk);
            bus_wr_ready = lfsr[0];
            lfsr         = lfsr_next(lfsr);
        end
    end

    task automatic apb_write(input logic [12:0] addr, input logic [15:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        assert (pready === 1'b1 && pslverr === 1'b0) else begin
            abort_run($sformatf("APB write to %h did not complete cleanly", addr));
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [12:0] addr, output logic [15:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        data = prdata;
        assert (pready === 1'b1 && pslverr === 1'b0) else begin
            abort_run($sformatf("APB read from %h did not complete cleanly", addr));
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Two words per instruction through the memory window
    task automatic load_program(input logic [10:0] base);
        logic [10:0] addr;
        addr = base;
        foreach (prog_q[i]) begin
            apb_write({2'b01, addr}, prog_q[i][31:16]);
            apb_write({2'b01, addr + 11'd1}, prog_q[i][15:0]);
            addr = addr + 11'd2;
        end
        prog_q.delete();
    endtask

    task automatic set_beam(input logic [10:0] v, input logic [10:0] h);
        @(negedge clk);
        v_count = v;
        h_count = h;
    endtask

    task automatic halt_copper();
        apb_write(13'h0000, 16'h0000);
        repeat (4) @(negedge clk);
        seen_q.delete();
    endtask

    // Set the initial PC while disabled and then enable
    task automatic start_program(input logic [10:0] pc);
        apb_write(13'h0000, {5'd0, pc});
        apb_write(13'h0000, {1'b1, 4'd0, pc});
    endtask

    task automatic expect_write(input logic [15:0] addr, input logic [15:0] data);
        int           waited;
        copp_bus_wr_t got;
        waited = 0;
        while (seen_q.size() == 0 && waited < WRITE_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        assert (seen_q.size() != 0) else begin
            abort_run($sformatf("no bus write to %h arrived within %0d cycles",
                                addr, WRITE_TIMEOUT));
        end
        got = seen_q.pop_front();
        check_word("bus_wr_o.addr", addr, got.addr);
        check_word("bus_wr_o.data", data, got.data);
    endtask

    task automatic check_quiet(input int cycles, input string what);
        repeat (cycles) @(negedge clk);
        assert (seen_q.size() == 0 && bus_wr_valid === 1'b0) else begin
            abort_run($sformatf("an unexpected bus write appeared during %s", what));
        end
    endtask

    task automatic check_registers();
        logic [15:0] rd;
        // Enable and initial PC come out of reset cleared
        apb_read(13'h0000, rd);
        check_word("prdata_o", 16'h0000, rd);
        prog_q.push_back(park_insn());
        load_program(11'h000);
        apb_write(13'h0000, 16'h8000);
        apb_read(13'h0000, rd);
        check_word("prdata_o", 16'h8000, rd);
        apb_write(13'h0000, 16'h05A5);
        apb_read(13'h0000, rd);
        check_word("prdata_o", 16'h05A5, rd);
        // Window holds a nonzero word here but reads give zero
        apb_read(13'h0801, rd);
        check_word("prdata_o", 16'h0000, rd);
        apb_read(13'h0FFF, rd);
        check_word("prdata_o", 16'h0000, rd);
    endtask

    task automatic run_move_sequence();
        halt_copper();
        set_beam(11'd0, 11'd0);
        prog_q.push_back(enc_move(`COPP_OP_MOVER, 12'h012, 16'h1111));
        prog_q.push_back(enc_move(`COPP_OP_MOVEP, 12'h005, 16'h0F0F));
        prog_q.push_back(enc_move(`COPP_OP_MOVER, 12'h034, 16'hBEEF));
        prog_q.push_back(enc_move(`COPP_OP_MOVEP, 12'h0FF, 16'h1234));
        prog_q.push_back(enc_move(`COPP_OP_MOVER, 12'h001, 16'hA5A5));
        prog_q.push_back(park_insn());
        load_program(11'h000);
        start_program(11'h000);
        // Register moves land at 0x00xx and palette moves at the palette base
        expect_write(16'h0012, 16'h1111);
        expect_write(16'h8005, 16'h0F0F);
        expect_write(16'h0034, 16'hBEEF);
        expect_write(16'h80FF, 16'h1234);
        expect_write(16'h0001, 16'hA5A5);
        check_quiet(30, "the parked move sequence");
    endtask

    task automatic wait_on_beam();
        halt_copper();
        set_beam(11'd10, 11'd100);
        prog_q.push_back(enc_pos(`COPP_OP_WAIT, 11'd200, 11'd300, 4'b0000));
        prog_q.push_back(enc_move(`COPP_OP_MOVER, 12'h021, 16'h3333));
        // Only X gates the release with vertical ignored
        prog_q.push_back(enc_pos(`COPP_OP_WAIT, 11'd1000, 11'd500, 4'b0001));
        prog_q.push_back(enc_move(`COPP_OP_MOVER, 12'h022, 16'h4444));
        prog_q.push_back(park_insn());
        load_program(11'h000);
        start_program(11'h000);
        check_quiet(40, "a WAIT below its target");
        set_beam(11'd200, 11'd300);
        expect_write(16'h0021, 16'h3333);
        check_quiet(40, "a WAIT on X alone");
        set_beam(11'd5, 11'd500);
        expect_write(16'h0022, 16'h4444);
        check_quiet(20, "the parked WAIT program");
    endtask

    task automatic skip_on_position();
        halt_copper();
        set_beam(11'd50, 11'd50);
        // Condition met so the next move is skipped
        prog_q.push_back(enc_pos(`COPP_OP_SKIP, 11'd40, 11'd40, 4'b0000));
        prog_q.push_back(enc_move(`COPP_OP_MOVER, 12'h031, 16'hDEAD));
        prog_q.push_back(enc_move(`COPP_OP_MOVER, 12'h032, 16'h0001));
        // Vertical not reached so it falls through
        prog_q.push_back(enc_pos(`COPP_OP_SKIP, 11'd100, 11'd40, 4'b0000));
        prog_q.push_back(enc_move(`COPP_OP_MOVER, 12'h033, 16'h0002));
        prog_q.push_back(park_insn());
        load_program(11'h000);
        start_program(11'h000);
        expect_write(16'h0032, 16'h0001);
        expect_write(16'h0033, 16'h0002);
        check_quiet(30, "the parked SKIP program");
    endtask

    task automatic jump_and_patch();
        halt_copper();
        set_beam(11'd0, 11'd0);
        prog_q.push_back(enc_pos(`COPP_OP_JMP, 11'h040, 11'd0, 4'b0000));
        prog_q.push_back(enc_move(`COPP_OP_MOVER, 12'h041, 16'hBAD0));
        prog_q.push_back(park_insn());
        load_program(11'h000);
        // Patch the data word of the MOVER at 0x044
        prog_q.push_back(enc_move(`COPP_OP_MOVEC, 12'h045, 16'h7777));
        prog_q.push_back(enc_move(`COPP_OP_MOVER, 12'h042, 16'h5555));
        prog_q.push_back(enc_move(`COPP_OP_MOVER, 12'h043, 16'h0000));
        prog_q.push_back(park_insn());
        load_program(11'h040);
        start_program(11'h000);
        expect_write(16'h0042, 16'h5555);
        expect_write(16'h0043, 16'h7777);
        check_quiet(30, "the parked JMP program");
    endtask

    task automatic restart_and_disable();
        halt_copper();
        set_beam(11'd0, 11'd0);
        prog_q.push_back(enc_move(`COPP_OP_MOVER, 12'h051, 16'h6001));
        prog_q.push_back(park_insn());
        load_program(11'h100);
        start_program(11'h100);
        expect_write(16'h0051, 16'h6001);
        check_quiet(40, "the park before restart");
        // Restart reruns from the initial PC
        set_beam(RESTART_V, RESTART_H);
        expect_write(16'h0051, 16'h6001);
        check_quiet(40, "the park after restart");
        set_beam(11'd0, 11'd0);
        apb_write(13'h0000, 16'h0100);
        repeat (4) @(negedge clk);
        seen_q.delete();
        set_beam(RESTART_V, RESTART_H);
        check_quiet(60, "a restart with enable cleared");
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run($sformatf("watchdog expired after %0d cycles before the tests finished",
                            WATCHDOG_CYCLES));
    end

    initial begin
        copp_reset = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        h_count    = '0;
        v_count    = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        copp_reset = 1'b0;
        // Idle outputs straight after reset
        assert (bus_wr_valid === 1'b0) else begin
            abort_run($sformatf("mismatch at %0t ns: bus_wr_valid_o expected 0 actual %b",
                                $time, bus_wr_valid));
        end

        check_registers();
        run_move_sequence();
        wait_on_beam();
        skip_on_position();
        jump_and_patch();
        restart_and_disable();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+.
copper_pkg.sv
copper_apb_regs.sv
copper_prog_ram.sv
copper_fetch.sv
copper_exec.sv
copper_top.sv
tb_copper.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run tb_copper, check $(LOG)"
	@echo "  clean  remove the build folder and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module tb_copper -Mdir obj_dir -o sim_copper
	./obj_dir/sim_copper | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
